// ==== Makefile ====
# Verilator build and run of the control core testbench

VERILATOR ?= verilator
TOP       ?= tb_tama_core_top
FILELIST  ?= tama_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== src/core_clock_divider.sv ====
/*
  Speed-dependent divider for the CPU clock enable and the double-rate
  enable. New speeds take effect at the next wrap; halt freezes it.
*/
`timescale 1ns/1ns
`default_nettype none

module core_clock_divider #(
  parameter int unsigned BASE_DIV = 3600
) (
  input  wire logic                        clk_sys_117_964,
  input  wire logic                        pll_core_locked,
  input  wire tama_core_pkg::turbo_speed_t turbo_speed,
  input  wire logic                        ss_halt,
  output logic                             clk_en,
  output logic                             clk_2x_en
);

  localparam tama_core_pkg::clk_div_t DIV_1X  = tama_core_pkg::clk_div_t'(BASE_DIV);
  localparam tama_core_pkg::clk_div_t DIV_2X  = tama_core_pkg::clk_div_t'(BASE_DIV / 2);
  localparam tama_core_pkg::clk_div_t DIV_4X  = tama_core_pkg::clk_div_t'(BASE_DIV / 4);
  localparam tama_core_pkg::clk_div_t DIV_50X = tama_core_pkg::clk_div_t'(BASE_DIV / 50);

  tama_core_pkg::clk_div_t reload;
  tama_core_pkg::clk_div_t div_cnt;
  tama_core_pkg::clk_div_t half_pt;

  always_comb begin
    case (turbo_speed)
      3'd0:    reload = DIV_1X;
      3'd1:    reload = DIV_2X;
      3'd2:    reload = DIV_4X;
      3'd3:    reload = DIV_50X;
      // full speed
      default: reload = 12'd1;
    endcase
  end

  always_ff @(posedge clk_sys_117_964 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      div_cnt   <= DIV_1X;
      half_pt   <= DIV_2X;
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      if (!ss_halt) begin
        if (div_cnt == '0) begin
          div_cnt   <= reload;
          // half point held for the whole period
          half_pt   <= (reload == 12'd1) ? 12'd1 : (reload >> 1);
          clk_en    <= 1'b1;
          clk_2x_en <= 1'b1;
        end else begin
          div_cnt <= div_cnt - 12'd1;
          if (div_cnt == half_pt) clk_2x_en <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/core_reset_gen.sv ====
/*
  Core reset generator. Stretches a register-requested reset for
  RESET_HOLD cycles and a savestate reset across four 2x ticks.
*/
`timescale 1ns/1ns
`default_nettype none

module core_reset_gen #(
  parameter int unsigned RESET_HOLD = 32'h100000
) (
  input  wire logic clk_sys_117_964,
  input  wire logic pll_core_locked,
  input  wire logic reset_req,
  input  wire logic ss_begin_reset,
  input  wire logic clk_2x_en,
  output logic      core_reset
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [HOLD_W-1:0] hold_cnt;
  logic [2:0]        ss_cnt;
  logic              por_q;

  always_ff @(posedge clk_sys_117_964 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      por_q    <= 1'b1;
      hold_cnt <= '0;
      ss_cnt   <= '0;
    end else begin
      por_q <= 1'b0;

      if (reset_req) hold_cnt <= HOLD_W'(RESET_HOLD);
      else if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;

      // savestate reset waits for four double-rate ticks
      if (ss_begin_reset) ss_cnt <= 3'd4;
      else if (clk_2x_en && ss_cnt != '0) ss_cnt <= ss_cnt - 3'd1;
    end
  end

  assign core_reset = por_q || (hold_cnt != '0) || (ss_cnt != '0);

endmodule

`default_nettype wire

// ==== src/rom_store.sv ====
/*
  Program ROM, 8k x 16. Written from the bridge ROM window,
  read by the core with one cycle of latency, low 12 bits only.
*/
`timescale 1ns/1ns
`default_nettype none

module rom_store (
  input  wire logic                     clk_sys_117_964,
  input  wire tama_bus_pkg::rom_wr_t    rom_wr,
  input  wire tama_core_pkg::rom_addr_t rom_addr,
  output tama_core_pkg::rom_data_t      rom_data
);

  localparam int DEPTH = 2 ** $bits(tama_core_pkg::rom_addr_t);

  tama_core_pkg::rom_word_t mem [DEPTH];

  always_ff @(posedge clk_sys_117_964) begin
    if (rom_wr.valid) begin
      mem[rom_wr.addr] <= rom_wr.data;
    end
  end

  // instruction words are 12 bits
  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= mem[rom_addr][11:0];
  end

endmodule

`default_nettype wire

// ==== src/speed_control.sv ====
/*
  Turbo speed register with L1/R1 stepping, on-screen indicator timer,
  suppression window after activation, turbo cancel and audio mute.
  Delays are parameters so short values can be used in simulation.
*/
`timescale 1ns/1ns
`default_nettype none

module speed_control #(
  parameter int unsigned BUTTON_DELAY   = 33554431,
  parameter int unsigned UI_DELAY       = 134217727,
  parameter int unsigned SUPPRESS_TICKS = 32'h28000
) (
  input  wire logic                        clk_sys_117_964,
  input  wire logic                        pll_core_locked,
  input  wire tama_core_pkg::key_t         cont1_key,
  input  wire tama_bus_pkg::speed_wr_t     speed_wr,
  input  wire tama_bus_pkg::settings_t     settings,
  input  wire logic                        buzzer,
  input  wire logic                        ss_halt,
  input  wire logic                        clk_en,
  output tama_core_pkg::turbo_speed_t      turbo_speed,
  output logic                             show_turbo_ui,
  output tama_core_pkg::audio_t            audio_l
);

  localparam int BTN_W = $clog2(BUTTON_DELAY + 1);
  localparam int UI_W  = $clog2(UI_DELAY + 1);
  localparam int SUP_W = $clog2(SUPPRESS_TICKS + 1);

  typedef enum logic {KEY_IDLE, KEY_HOLD} key_state_e;

  key_state_e                  key_state;
  logic [BTN_W-1:0]            btn_cnt;
  logic [UI_W-1:0]             ui_cnt;
  logic [SUP_W-1:0]            sup_cnt;
  logic                        prev_zero;
  logic                        key_l1;
  logic                        key_r1;
  logic                        key_fire;
  logic                        suppress_start;
  logic                        cancel;
  logic                        ui_trigger;
  tama_core_pkg::turbo_speed_t wr_speed;
  tama_core_pkg::turbo_speed_t speed_next;

  assign key_l1   = cont1_key[tama_core_pkg::KEY_L1];
  assign key_r1   = cont1_key[tama_core_pkg::KEY_R1];
  assign key_fire = (key_state == KEY_IDLE) && (key_l1 || key_r1);

  // fresh activation opens the suppression window
  assign suppress_start = prev_zero && (turbo_speed != '0) && settings.suppress_after_activation;
  assign cancel = ss_halt ||
                  (buzzer && settings.cancel_on_event && !suppress_start && (sup_cnt == '0));

  assign wr_speed = (speed_wr.speed > tama_core_pkg::SPEED_MAX) ?
                    tama_core_pkg::SPEED_MAX : speed_wr.speed;

  ////////////////////////////////////////////////////////////
  // next speed, priority rises top to bottom
  always_comb begin
    speed_next = turbo_speed;
    ui_trigger = 1'b0;
    if (key_fire) begin
      ui_trigger = 1'b1;
      if (key_l1) begin
        if (turbo_speed != '0) speed_next = turbo_speed - 3'd1;
      end else if (turbo_speed < tama_core_pkg::SPEED_MAX) begin
        speed_next = turbo_speed + 3'd1;
      end
    end
    if (speed_wr.valid) speed_next = wr_speed;
    if (cancel) begin
      speed_next = '0;
      if (turbo_speed != '0) ui_trigger = 1'b1;
    end
  end

  always_ff @(posedge clk_sys_117_964 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      turbo_speed <= '0;
      prev_zero   <= 1'b1;
      key_state   <= KEY_IDLE;
      btn_cnt     <= '0;
      ui_cnt      <= '0;
      sup_cnt     <= '0;
    end else begin
      turbo_speed <= speed_next;
      prev_zero   <= (turbo_speed == '0);

      // key repeat, released keys rearm at once
      if (!key_l1 && !key_r1) begin
        key_state <= KEY_IDLE;
        btn_cnt   <= '0;
      end else if (key_fire) begin
        key_state <= KEY_HOLD;
        btn_cnt   <= BTN_W'(BUTTON_DELAY);
      end else if (key_state == KEY_HOLD) begin
        btn_cnt <= btn_cnt - 1'b1;
        if (btn_cnt <= 1) key_state <= KEY_IDLE;
      end

      if (ui_trigger) ui_cnt <= UI_W'(UI_DELAY);
      else if (ui_cnt != '0) ui_cnt <= ui_cnt - 1'b1;

      // window counts in core time
      if (suppress_start) sup_cnt <= SUP_W'(SUPPRESS_TICKS);
      else if (clk_en && sup_cnt != '0) sup_cnt <= sup_cnt - 1'b1;
    end
  end

  assign show_turbo_ui = (ui_cnt != '0);

  // buzzer is unpleasant at high speed
  assign audio_l = (!settings.disable_sound && turbo_speed < 3'd2) ?
                   {2'b00, {13{buzzer}}} : '0;

  a_speed_range: assert property (@(posedge clk_sys_117_964)
    disable iff (!pll_core_locked) turbo_speed <= tama_core_pkg::SPEED_MAX);

endmodule

`default_nettype wire

// ==== src/tama_bus_pkg.sv ====
/*
  Bridge bus types, the settings register map and the strobe structs
  that leave the register block. Depends on tama_core_pkg types.
*/
`default_nettype none

package tama_bus_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  ////////////////////////////////////////////////////////////
  // register map
  localparam bridge_addr_t ADDR_RESET    = 32'h0000_0000;
  localparam bridge_addr_t ADDR_SOUND    = 32'h0000_0010;
  localparam bridge_addr_t ADDR_TURBO    = 32'h0000_0100;
  localparam bridge_addr_t ADDR_CANCEL   = 32'h0000_0104;
  localparam bridge_addr_t ADDR_SUPPRESS = 32'h0000_0108;

  // upper nibble of the ROM load window
  localparam logic [3:0] ROM_REGION = 4'h1;

  typedef struct packed {
    logic disable_sound;
    logic cancel_on_event;
    logic suppress_after_activation;
  } settings_t;

  typedef struct packed {
    logic                       valid;
    tama_core_pkg::turbo_speed_t speed;
  } speed_wr_t;

  typedef struct packed {
    logic                    valid;
    tama_core_pkg::rom_addr_t addr;
    tama_core_pkg::rom_word_t data;
  } rom_wr_t;

endpackage

`default_nettype wire

// ==== src/tama_core_pkg.sv ====
/*
  Core-side widths and types for the handheld-pet control core.
  Speed setting, divider count, key bitmap, ROM and audio types.
  Referenced by scoped name from the bus package and from the RTL.
*/
`default_nettype none

package tama_core_pkg;

  // turbo speed, 0 is 1x and 4 is full speed
  typedef logic [2:0] turbo_speed_t;
  localparam turbo_speed_t SPEED_MAX = 3'd4;

  // clock divider reload and count
  typedef logic [11:0] clk_div_t;

  // controller key bitmap
  typedef logic [15:0] key_t;
  localparam int KEY_L1 = 8;
  localparam int KEY_R1 = 9;

  // program ROM, 8k words of 16 bits, read back 12 bits wide
  typedef logic [12:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [11:0] rom_data_t;

  // one audio channel sample
  typedef logic [14:0] audio_t;

endpackage

`default_nettype wire

// ==== src/tama_core_top.sv ====
/*
  Top level of the slow-clock control core. Holds the timing parameters
  and connects registers, speed control, divider, reset and ROM.
*/
`timescale 1ns/1ns
`default_nettype none

module tama_core_top #(
  parameter int unsigned BASE_DIV       = 3600,
  parameter int unsigned BUTTON_DELAY   = 33554431,
  parameter int unsigned UI_DELAY       = 134217727,
  parameter int unsigned SUPPRESS_TICKS = 32'h28000,
  parameter int unsigned RESET_HOLD     = 32'h100000
) (
  input  wire logic                       clk_sys_117_964,
  input  wire logic                       pll_core_locked,
  input  wire tama_bus_pkg::bridge_addr_t bridge_addr,
  input  wire logic                       bridge_wr,
  input  wire logic                       bridge_rd,
  input  wire tama_bus_pkg::bridge_data_t bridge_wr_data,
  input  wire tama_core_pkg::key_t        cont1_key,
  input  wire logic                       buzzer,
  input  wire logic                       ss_halt,
  input  wire logic                       ss_begin_reset,
  input  wire tama_core_pkg::rom_addr_t   rom_addr,
  output tama_bus_pkg::bridge_data_t      bridge_rd_data,
  output tama_core_pkg::rom_data_t        rom_data,
  output logic                            clk_en,
  output logic                            clk_2x_en,
  output logic                            core_reset,
  output tama_core_pkg::turbo_speed_t     turbo_speed,
  output logic                            show_turbo_ui,
  output tama_core_pkg::audio_t           audio_l
);

  tama_bus_pkg::settings_t settings;
  tama_bus_pkg::speed_wr_t speed_wr;
  tama_bus_pkg::rom_wr_t   rom_wr;
  logic                    reset_req;

  ////////////////////////////////////////////////////////////
  // bridge side
  tama_settings_regs tama_settings_regs_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_rd       (bridge_rd),
    .bridge_wr_data  (bridge_wr_data),
    .turbo_speed     (turbo_speed),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .speed_wr        (speed_wr),
    .reset_req       (reset_req),
    .rom_wr          (rom_wr)
  );

  rom_store rom_store_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .rom_wr          (rom_wr),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

  ////////////////////////////////////////////////////////////
  // speed and core timing
  speed_control #(
    .BUTTON_DELAY   (BUTTON_DELAY),
    .UI_DELAY       (UI_DELAY),
    .SUPPRESS_TICKS (SUPPRESS_TICKS)
  ) speed_control_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .pll_core_locked (pll_core_locked),
    .cont1_key       (cont1_key),
    .speed_wr        (speed_wr),
    .settings        (settings),
    .buzzer          (buzzer),
    .ss_halt         (ss_halt),
    .clk_en          (clk_en),
    .turbo_speed     (turbo_speed),
    .show_turbo_ui   (show_turbo_ui),
    .audio_l         (audio_l)
  );

  core_clock_divider #(
    .BASE_DIV (BASE_DIV)
  ) core_clock_divider_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .pll_core_locked (pll_core_locked),
    .turbo_speed     (turbo_speed),
    .ss_halt         (ss_halt),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en)
  );

  core_reset_gen #(
    .RESET_HOLD (RESET_HOLD)
  ) core_reset_gen_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .pll_core_locked (pll_core_locked),
    .reset_req       (reset_req),
    .ss_begin_reset  (ss_begin_reset),
    .clk_2x_en       (clk_2x_en),
    .core_reset      (core_reset)
  );

endmodule

`default_nettype wire

// ==== src/tama_settings_regs.sv ====
/*
  Settings register block on the bridge bus. Setting bits update on the
  write edge, strobes leave one cycle later. Read mux is combinational.
*/
`timescale 1ns/1ns
`default_nettype none

module tama_settings_regs (
  input  wire logic                        clk_sys_117_964,
  input  wire logic                        pll_core_locked,
  input  wire tama_bus_pkg::bridge_addr_t  bridge_addr,
  input  wire logic                        bridge_wr,
  input  wire logic                        bridge_rd,
  input  wire tama_bus_pkg::bridge_data_t  bridge_wr_data,
  input  wire tama_core_pkg::turbo_speed_t turbo_speed,
  output tama_bus_pkg::bridge_data_t       bridge_rd_data,
  output tama_bus_pkg::settings_t          settings,
  output tama_bus_pkg::speed_wr_t          speed_wr,
  output logic                             reset_req,
  output tama_bus_pkg::rom_wr_t            rom_wr
);

  logic rom_hit;

  assign rom_hit = bridge_wr && (bridge_addr[31:28] == tama_bus_pkg::ROM_REGION);

  always_ff @(posedge clk_sys_117_964 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings  <= '0;
      speed_wr  <= '0;
      reset_req <= 1'b0;
      rom_wr    <= '0;
    end else begin
      speed_wr.valid <= 1'b0;
      reset_req      <= 1'b0;
      rom_wr.valid   <= 1'b0;

      if (bridge_wr) begin
        case (bridge_addr)
          tama_bus_pkg::ADDR_RESET:    reset_req <= 1'b1;
          tama_bus_pkg::ADDR_SOUND:    settings.disable_sound <= bridge_wr_data[0];
          tama_bus_pkg::ADDR_TURBO: begin
            speed_wr.valid <= 1'b1;
            speed_wr.speed <= bridge_wr_data[2:0];
          end
          tama_bus_pkg::ADDR_CANCEL:   settings.cancel_on_event <= bridge_wr_data[0];
          tama_bus_pkg::ADDR_SUPPRESS: settings.suppress_after_activation <= bridge_wr_data[0];
          default: ;
        endcase
      end

      // word addressed, bytes arrive big endian
      if (rom_hit) begin
        rom_wr.valid <= 1'b1;
        rom_wr.addr  <= bridge_addr[13:1];
        rom_wr.data  <= {bridge_wr_data[7:0], bridge_wr_data[15:8]};
      end
    end
  end

  // only the speed register reads back
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == tama_bus_pkg::ADDR_TURBO) begin
      bridge_rd_data = tama_bus_pkg::bridge_data_t'(turbo_speed);
    end
  end

  a_strobe_exclusive: assert property (@(posedge clk_sys_117_964)
    disable iff (!pll_core_locked) !(speed_wr.valid && rom_wr.valid));

  // host never reads and writes in the same cycle
  a_rd_wr_exclusive: assert property (@(posedge clk_sys_117_964)
    disable iff (!pll_core_locked) !(bridge_rd && bridge_wr));

endmodule

`default_nettype wire

// ==== tama_core.f ====
src/tama_core_pkg.sv
src/tama_bus_pkg.sv
src/tama_settings_regs.sv
src/speed_control.sv
src/core_clock_divider.sv
src/core_reset_gen.sv
src/rom_store.sv
src/tama_core_top.sv
tb/tb_tama_core_top.sv

// ==== tb/tb_tama_core_top.sv ====
/*
  Directed testbench for the control core top level. Drives bridge writes,
  keys, buzzer and savestate inputs on the falling clock edge and checks
  speed, clock enables, core reset, audio and the ROM read path.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_tama_core_top;

  localparam int unsigned CLK_PERIOD     = 10;
  localparam int unsigned BASE_DIV       = 200;
  localparam int unsigned BUTTON_DELAY   = 8;
  localparam int unsigned UI_DELAY       = 40;
  localparam int unsigned SUPPRESS_TICKS = 3;
  localparam int unsigned RESET_HOLD     = 20;
  localparam int unsigned SPEED_CAP      = 4;
  localparam int unsigned DIV_WINDOW     = 2000;
  localparam int unsigned HALT_WINDOW    = 500;
  localparam int unsigned ROM_WORDS      = 16;
  localparam int unsigned HALF_PERIOD    = BASE_DIV / 2 + 1;

  // cycle budget of each test
  localparam int unsigned T_REGS  = 40;
  localparam int unsigned T_KEYS  = 10 * 8 + 40;
  localparam int unsigned T_DIV   = 5 * (BASE_DIV + DIV_WINDOW + 10) + HALT_WINDOW + 10;
  localparam int unsigned T_AUDIO = 20 * 12 + 80 + SUPPRESS_TICKS * 2 * HALF_PERIOD;
  localparam int unsigned T_RESET = RESET_HOLD + 60 + 5 * HALF_PERIOD;
  localparam int unsigned T_ROM   = ROM_WORDS * 6;
  localparam int unsigned WATCHDOG_CYCLES =
    2 * (16 + T_REGS + T_KEYS + T_DIV + T_AUDIO + T_RESET + T_ROM);

  logic                        clk_sys_117_964;
  logic                        pll_core_locked;
  tama_bus_pkg::bridge_addr_t  bridge_addr;
  logic                        bridge_wr;
  logic                        bridge_rd;
  tama_bus_pkg::bridge_data_t  bridge_wr_data;
  tama_core_pkg::key_t         cont1_key;
  logic                        buzzer;
  logic                        ss_halt;
  logic                        ss_begin_reset;
  tama_core_pkg::rom_addr_t    rom_addr;
  tama_bus_pkg::bridge_data_t  bridge_rd_data;
  tama_core_pkg::rom_data_t    rom_data;
  logic                        clk_en;
  logic                        clk_2x_en;
  logic                        core_reset;
  tama_core_pkg::turbo_speed_t turbo_speed;
  logic                        show_turbo_ui;
  tama_core_pkg::audio_t       audio_l;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  logic [31:0] lcg_state;

  tama_core_top #(
    .BASE_DIV       (BASE_DIV),
    .BUTTON_DELAY   (BUTTON_DELAY),
    .UI_DELAY       (UI_DELAY),
    .SUPPRESS_TICKS (SUPPRESS_TICKS),
    .RESET_HOLD     (RESET_HOLD)
  ) tama_core_top_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_rd       (bridge_rd),
    .bridge_wr_data  (bridge_wr_data),
    .cont1_key       (cont1_key),
    .buzzer          (buzzer),
    .ss_halt         (ss_halt),
    .ss_begin_reset  (ss_begin_reset),
    .rom_addr        (rom_addr),
    .bridge_rd_data  (bridge_rd_data),
    .rom_data        (rom_data),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en),
    .core_reset      (core_reset),
    .turbo_speed     (turbo_speed),
    .show_turbo_ui   (show_turbo_ui),
    .audio_l         (audio_l)
  );

  always #(CLK_PERIOD / 2) clk_sys_117_964 = ~clk_sys_117_964;

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // pulls a count inside the tolerance onto the expected value
  function automatic logic [31:0] snap_within(input logic [31:0] got, input logic [31:0] exp,
                                              input int unsigned tol);
    logic [31:0] diff;
    diff = (got > exp) ? got - exp : exp - got;
    return (diff <= tol) ? exp : got;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // divider reload for each speed
  function automatic int unsigned expected_reload(input int unsigned speed);
    case (speed)
      0:       return BASE_DIV;
      1:       return BASE_DIV / 2;
      2:       return BASE_DIV / 4;
      3:       return BASE_DIV / 50;
      default: return 1;
    endcase
  endfunction

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests++;
    $display("test %s %s", name, (errors == errors_before) ? "ok" : "failed");
  endtask

  task automatic bus_write(input tama_bus_pkg::bridge_addr_t addr,
                           input tama_bus_pkg::bridge_data_t data);
    @(negedge clk_sys_117_964);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_sys_117_964);
    bridge_wr      = 1'b0;
  endtask

  task automatic bus_read(input tama_bus_pkg::bridge_addr_t addr,
                          output tama_bus_pkg::bridge_data_t data);
    @(negedge clk_sys_117_964);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(negedge clk_sys_117_964);
    data      = bridge_rd_data;
    bridge_rd = 1'b0;
  endtask

  // speed lands two cycles after the write
  task automatic set_speed(input int unsigned speed);
    bus_write(tama_bus_pkg::ADDR_TURBO, speed);
    repeat (2) @(negedge clk_sys_117_964);
  endtask

  task automatic press_key(input int key_bit);
    @(negedge clk_sys_117_964);
    cont1_key[key_bit] = 1'b1;
    repeat (2) @(negedge clk_sys_117_964);
    cont1_key = '0;
    @(negedge clk_sys_117_964);
  endtask

  task automatic count_enables(input int unsigned cycles, output int unsigned n_en,
                               output int unsigned n_2x);
    n_en = 0;
    n_2x = 0;
    repeat (cycles) begin
      @(negedge clk_sys_117_964);
      if (clk_en) n_en++;
      if (clk_2x_en) n_2x++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic register_access();
    int unsigned                err0;
    tama_bus_pkg::bridge_data_t rd;
    err0 = errors;
    bus_read(tama_bus_pkg::ADDR_TURBO, rd);
    check("bridge_rd_data turbo", rd, 32'd0);
    set_speed(3);
    bus_read(tama_bus_pkg::ADDR_TURBO, rd);
    check("bridge_rd_data turbo", rd, 32'd3);
    bus_read(32'h0000_0200, rd);
    check("bridge_rd_data unmapped", rd, 32'd0);
    finish_test("registers", err0);
  endtask

  task automatic key_stepping();
    int unsigned err0;
    int unsigned exp;
    err0 = errors;
    set_speed(0);
    exp = 0;
    for (int i = 0; i < 5; i++) begin
      press_key(tama_core_pkg::KEY_R1);
      if (exp < SPEED_CAP) exp++;
      check("turbo_speed", 32'(turbo_speed), exp);
      check("show_turbo_ui", 32'(show_turbo_ui), 32'd1);
    end
    for (int i = 0; i < 5; i++) begin
      press_key(tama_core_pkg::KEY_L1);
      if (exp > 0) exp--;
      check("turbo_speed", 32'(turbo_speed), exp);
      check("show_turbo_ui", 32'(show_turbo_ui), 32'd1);
    end
    finish_test("key stepping", err0);
  endtask

  task automatic divider_rates();
    int unsigned err0;
    int unsigned n_en;
    int unsigned n_2x;
    int unsigned exp_en;
    int unsigned exp_2x;
    err0 = errors;
    for (int unsigned s = 0; s <= SPEED_CAP; s++) begin
      set_speed(s);
      // new reload only after the next wrap
      repeat (BASE_DIV + 2) @(negedge clk_sys_117_964);
      count_enables(DIV_WINDOW, n_en, n_2x);
      exp_en = DIV_WINDOW / (expected_reload(s) + 1);
      exp_2x = 2 * DIV_WINDOW / (expected_reload(s) + 1);
      check("clk_en count", snap_within(n_en, exp_en, 1), exp_en);
      if (s < SPEED_CAP) begin
        check("clk_2x_en count", snap_within(n_2x, exp_2x, 2), exp_2x);
      end
    end
    @(negedge clk_sys_117_964);
    ss_halt = 1'b1;
    @(negedge clk_sys_117_964);
    count_enables(HALT_WINDOW, n_en, n_2x);
    check("clk_en while halted", n_en, 32'd0);
    check("clk_2x_en while halted", n_2x, 32'd0);
    check("turbo_speed after halt", 32'(turbo_speed), 32'd0);
    @(negedge clk_sys_117_964);
    ss_halt = 1'b0;
    finish_test("clock divider", err0);
  endtask

  task automatic audio_and_cancel();
    int unsigned err0;
    int unsigned ticks;
    int unsigned n;
    logic [31:0] exp;
    err0 = errors;
    for (int unsigned snd_off = 0; snd_off < 2; snd_off++) begin
      bus_write(tama_bus_pkg::ADDR_SOUND, snd_off);
      for (int unsigned s = 0; s <= SPEED_CAP; s++) begin
        set_speed(s);
        for (int unsigned b = 0; b < 2; b++) begin
          buzzer = b[0];
          @(negedge clk_sys_117_964);
          exp = (snd_off == 0 && s < 2 && b == 1) ? 32'h1fff : 32'h0;
          check("audio_l", 32'(audio_l), exp);
        end
        buzzer = 1'b0;
      end
    end
    bus_write(tama_bus_pkg::ADDR_SOUND, 32'd0);

    // buzzer cancels turbo
    bus_write(tama_bus_pkg::ADDR_CANCEL, 32'd1);
    set_speed(1);
    check("show_turbo_ui before cancel", 32'(show_turbo_ui), 32'd0);
    buzzer = 1'b1;
    repeat (2) @(negedge clk_sys_117_964);
    check("turbo_speed after cancel", 32'(turbo_speed), 32'd0);
    check("show_turbo_ui after cancel", 32'(show_turbo_ui), 32'd1);
    buzzer = 1'b0;

    // fresh activation holds off the cancel for a few core ticks
    bus_write(tama_bus_pkg::ADDR_SUPPRESS, 32'd1);
    set_speed(1);
    check("turbo_speed on activation", 32'(turbo_speed), 32'd1);
    buzzer = 1'b1;
    ticks = 0;
    n = 0;
    while (turbo_speed != '0 && n < (SUPPRESS_TICKS + 1) * HALF_PERIOD * 2) begin
      if (clk_en) ticks++;
      @(negedge clk_sys_117_964);
      n++;
    end
    if (turbo_speed != '0) begin
      errors++;
      $display("buzzer never cancelled turbo after the suppression window");
    end
    check("clk_en ticks before cancel", ticks, SUPPRESS_TICKS);
    buzzer = 1'b0;
    bus_write(tama_bus_pkg::ADDR_CANCEL, 32'd0);
    bus_write(tama_bus_pkg::ADDR_SUPPRESS, 32'd0);
    finish_test("audio and cancel", err0);
  endtask

  task automatic core_reset_stretch();
    int unsigned err0;
    int unsigned high;
    int unsigned pulses;
    int unsigned n;
    err0 = errors;
    check("core_reset idle", 32'(core_reset), 32'd0);
    bus_write(tama_bus_pkg::ADDR_RESET, 32'd0);
    n = 0;
    while (!core_reset && n < 10) begin
      @(negedge clk_sys_117_964);
      n++;
    end
    high = 0;
    while (core_reset && high < RESET_HOLD + 10) begin
      high++;
      @(negedge clk_sys_117_964);
    end
    if (core_reset) begin
      errors++;
      $display("core_reset stayed high after the register reset");
    end
    check("core_reset hold cycles", (high >= RESET_HOLD) ? RESET_HOLD : high, RESET_HOLD);

    @(negedge clk_sys_117_964);
    ss_begin_reset = 1'b1;
    @(negedge clk_sys_117_964);
    ss_begin_reset = 1'b0;
    pulses = 0;
    n = 0;
    while (core_reset && n < 5 * HALF_PERIOD + 10) begin
      if (clk_2x_en) pulses++;
      @(negedge clk_sys_117_964);
      n++;
    end
    if (core_reset) begin
      errors++;
      $display("core_reset stayed high after the savestate reset");
    end
    check("clk_2x_en pulses in core_reset", pulses, 32'd4);
    finish_test("core reset", err0);
  endtask

  task automatic rom_readback();
    int unsigned              err0;
    tama_core_pkg::rom_addr_t addrs [ROM_WORDS];
    logic [15:0]              words [ROM_WORDS];
    err0 = errors;
    for (int unsigned i = 0; i < ROM_WORDS; i++) begin
      lcg_state = lcg_next(lcg_state);
      words[i] = lcg_state[31:16];
      addrs[i] = 13'(i * 517 + 3);
      bus_write({tama_bus_pkg::ROM_REGION, 14'h0, addrs[i], 1'b0}, {16'h0, words[i]});
    end
    repeat (2) @(negedge clk_sys_117_964);
    for (int unsigned i = 0; i < ROM_WORDS; i++) begin
      rom_addr = addrs[i];
      @(negedge clk_sys_117_964);
      check("rom_data", 32'(rom_data), 32'(12'({words[i][7:0], words[i][15:8]})));
    end
    finish_test("rom", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk_sys_117_964 = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_rd       = 1'b0;
    bridge_wr_data  = '0;
    cont1_key       = '0;
    buzzer          = 1'b0;
    ss_halt         = 1'b0;
    ss_begin_reset  = 1'b0;
    rom_addr        = '0;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    lcg_state       = 32'd17;
    repeat (16) @(posedge clk_sys_117_964);
    @(negedge clk_sys_117_964);
    pll_core_locked = 1'b1;
    @(negedge clk_sys_117_964);

    register_access();
    key_stepping();
    divider_rates();
    audio_and_cancel();
    core_reset_stretch();
    rom_readback();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
